/* rtl/cgra_pkg.sv */
package cgra_pkg;

  // **************************************************
  // Sizes.
  // **************************************************
  localparam int num_threads = 8;
  localparam int fifo_depth = 16;
  localparam int pipe_depth = 3;  // Issue to FIFO write, in steps.

  localparam int pc_w = 5;
  localparam int const_addr_w = 4;
  localparam int inst_depth = num_threads << pc_w;
  localparam int const_depth = num_threads << const_addr_w;
  localparam int fifo_aw = $clog2(fifo_depth);

  typedef logic [2:0]              thread_t;
  typedef logic [pc_w-1:0]         pc_t;
  typedef logic [const_addr_w-1:0] const_addr_t;
  typedef logic [15:0]             data_t;
  typedef logic [15:0]             qty_t;
  typedef logic [7:0]              ign_t;
  typedef logic [7:0]              seq_t;
  typedef logic [fifo_aw-1:0]      fifo_ptr_t;
  typedef logic [fifo_aw:0]        fifo_cnt_t;

  localparam fifo_cnt_t fifo_full = fifo_cnt_t'(fifo_depth);
  localparam fifo_cnt_t fifo_space_min = fifo_cnt_t'(fifo_depth - pipe_depth - 1);

  // **************************************************
  // Encodings and bundles.
  // **************************************************
  typedef enum logic [2:0] {
    op_pass_a, op_add, op_sub, op_mul, op_and, op_or, op_xor, op_max
  } alu_op_e;

  typedef enum logic [2:0] {
    kind_inst, kind_const, kind_pc_max, kind_pc_loop, kind_ignore, kind_qty
  } conf_kind_e;

  typedef struct packed {
    alu_op_e     op;
    logic        b_const;     // Constant replaces inb.
    const_addr_t const_addr;
    logic        emit;        // Result goes to the FIFO.
    logic        out_en;      // Result updates outa.
    logic [5:0]  spare;
  } inst_t;

  typedef struct packed {
    logic [3:0] pe_id;
    conf_kind_e kind;
    thread_t    thread;
    pc_t        addr;
    logic       reserved;
    data_t      data;
  } conf_word_t;

  typedef struct packed {
    thread_t thread;
    data_t   data;
  } result_t;

  typedef struct packed {
    thread_t thread;
    seq_t    seq;
    data_t   data;
  } out_word_t;

  function automatic data_t alu_eval(alu_op_e op, data_t a, data_t b);
    data_t r;
    case (op)
      op_pass_a: r = a;
      op_add:    r = a + b;
      op_sub:    r = a - b;
      op_mul:    r = a * b;  // Low half of the product.
      op_and:    r = a & b;
      op_or:     r = a | b;
      op_xor:    r = a ^ b;
      op_max:    r = (a > b) ? a : b;
      default:   r = a;
    endcase
    return r;
  endfunction

endpackage

/* rtl/cgra_conf_reader.sv */
`timescale 1ns/1ps

module cgra_conf_reader #(
  parameter logic [3:0] PE_ID = 4'd0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 conf_valid,
  input  cgra_pkg::conf_word_t conf_word,
  output logic                 conf_we,
  output cgra_pkg::conf_kind_e conf_kind,
  output cgra_pkg::thread_t    conf_thread,
  output cgra_pkg::pc_t        conf_addr,
  output cgra_pkg::data_t      conf_data
);

  import cgra_pkg::*;

  logic match;

  assign match = conf_valid && (conf_word.pe_id == PE_ID);  // Words for other PEs drop here.

  always_ff @(posedge clk) begin
    if (rst) begin
      conf_we <= 1'b0;
    end else begin
      conf_we <= match;
    end
  end

  always_ff @(posedge clk) begin
    if (match) begin
      conf_kind   <= conf_word.kind;
      conf_thread <= conf_word.thread;
      conf_addr   <= conf_word.addr;
      conf_data   <= conf_word.data;
    end
  end

  // **************************************************
  // Checks.
  // **************************************************
  a_kind_defined : assert property (
    @(posedge clk) disable iff (rst)
    conf_we |-> (conf_kind inside {kind_inst, kind_const, kind_pc_max,
                                  kind_pc_loop, kind_ignore, kind_qty})
  );

endmodule

/* rtl/cgra_pe_out.sv */
`timescale 1ns/1ps

module cgra_pe_out (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  logic                 space,
  input  logic                 conf_we,
  input  cgra_pkg::conf_kind_e conf_kind,
  input  cgra_pkg::thread_t    conf_thread,
  input  cgra_pkg::pc_t        conf_addr,
  input  cgra_pkg::data_t      conf_data,
  input  cgra_pkg::data_t      ina,
  input  cgra_pkg::data_t      inb,
  output logic                 push,
  output cgra_pkg::result_t    push_data,
  output cgra_pkg::data_t      outa,
  output logic                 done
);

  import cgra_pkg::*;

  logic step;
  thread_t thr;

  pc_t  pc_max_tab [num_threads];
  pc_t  pc_loop_tab [num_threads];
  ign_t ign_tab [num_threads];
  qty_t qty_tab [num_threads];

  pc_t  pc [num_threads];
  ign_t ign_cnt [num_threads];
  qty_t emitted [num_threads];
  logic [num_threads-1:0] reached;
  logic ign_used;

  inst_t inst_mem [inst_depth];
  data_t const_mem [const_depth];

  logic    s1_vld;
  thread_t s1_thread;
  inst_t   s1_inst;
  logic    s2_vld;
  thread_t s2_thread;
  inst_t   s2_inst;
  data_t   s2_a;
  data_t   s2_b;
  logic    s3_vld;
  thread_t s3_thread;
  logic    s3_emit;
  logic    s3_out_en;
  data_t   s3_res;

  assign step = run && space;  // Low space freezes the whole pipeline.

  // **************************************************
  // Configuration tables and memories.
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < num_threads; t++) begin
        pc_max_tab[t]  <= '0;
        pc_loop_tab[t] <= '0;
        ign_tab[t]     <= '0;
        qty_tab[t]     <= '0;
      end
    end else if (conf_we) begin
      case (conf_kind)
        kind_pc_max:  pc_max_tab[conf_thread] <= pc_t'(conf_data);
        kind_pc_loop: pc_loop_tab[conf_thread] <= pc_t'(conf_data);
        kind_ignore:  ign_tab[conf_thread] <= ign_t'(conf_data);
        kind_qty:     qty_tab[conf_thread] <= conf_data;  // Full 16-bit limit.
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (conf_we && conf_kind == kind_inst) begin
      inst_mem[{conf_thread, conf_addr}] <= inst_t'(conf_data);
    end
    if (conf_we && conf_kind == kind_const) begin
      const_mem[{conf_thread, const_addr_t'(conf_addr)}] <= conf_data;
    end
  end

  // **************************************************
  // Thread rotation and program counters.
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      thr <= '0;
      for (int t = 0; t < num_threads; t++) begin
        pc[t] <= '0;
      end
    end else if (step) begin
      thr <= (thr == thread_t'(num_threads - 1)) ? '0 : thr + 1'b1;
      pc[thr] <= (pc[thr] == pc_max_tab[thr]) ? pc_loop_tab[thr] : pc[thr] + 1'b1;
    end
  end

  // **************************************************
  // Fetch, decode and ALU stages.
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
      s3_vld <= 1'b0;
    end else if (step) begin
      s1_vld <= 1'b1;
      s2_vld <= s1_vld;
      s3_vld <= s2_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      s1_thread <= thr;
      s1_inst   <= inst_mem[{thr, pc[thr]}];
      s2_thread <= s1_thread;
      s2_inst   <= s1_inst;
      s2_a      <= ina;
      s2_b      <= s1_inst.b_const ? const_mem[{s1_thread, s1_inst.const_addr}] : inb;
      s3_thread <= s2_thread;
      s3_emit   <= s2_inst.emit;
      s3_out_en <= s2_inst.out_en;
      s3_res    <= alu_eval(s2_inst.op, s2_a, s2_b);
    end
  end

  // **************************************************
  // Ignore and quantity gating.
  // **************************************************
  assign ign_used = (ign_cnt[s3_thread] == ign_tab[s3_thread]);

  always_comb begin
    for (int t = 0; t < num_threads; t++) begin
      reached[t] = (emitted[t] == qty_tab[t]);  // A zero quantity is reached at once.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      push <= 1'b0;
      outa <= '0;
      done <= 1'b0;
      for (int t = 0; t < num_threads; t++) begin
        ign_cnt[t] <= '0;
        emitted[t] <= '0;
      end
    end else begin
      push <= 1'b0;
      done <= run && (&reached);
      if (step && s3_vld) begin
        if (s3_emit && !ign_used) begin
          ign_cnt[s3_thread] <= ign_cnt[s3_thread] + 1'b1;  // Result swallowed.
        end else if (s3_emit && !reached[s3_thread]) begin
          push <= 1'b1;
          emitted[s3_thread] <= emitted[s3_thread] + 1'b1;
        end
        if (s3_out_en) begin
          outa <= s3_res;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      push_data <= {s3_thread, s3_res};
    end
  end

  a_conf_idle_in_run : assert property (
    @(posedge clk) disable iff (rst)
    conf_we |-> !run
  );

endmodule

/* rtl/cgra_out_fifo.sv */
`timescale 1ns/1ps

module cgra_out_fifo (
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  cgra_pkg::result_t push_data,
  input  logic              pop,
  output cgra_pkg::result_t pop_data,
  output logic              empty,
  output logic              space
);

  import cgra_pkg::*;

  result_t   mem [fifo_depth];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, pointers wrap.
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign pop_data = mem[rd_ptr];  // Head word is visible before the pop.
  assign empty = (count == '0);
  assign space = (count <= fifo_space_min);  // Room for every item in flight.

  a_no_overflow : assert property (
    @(posedge clk) disable iff (rst)
    push |-> count != fifo_full
  );

  a_no_underflow : assert property (
    @(posedge clk) disable iff (rst)
    pop |-> !empty
  );

endmodule

/* rtl/cgra_out_drain.sv */
`timescale 1ns/1ps

module cgra_out_drain (
  input  logic                clk,
  input  logic                rst,
  input  logic                drain_en,
  input  logic                empty,
  input  cgra_pkg::result_t   pop_data,
  output logic                pop,
  output logic                out_valid,
  output cgra_pkg::out_word_t out_word
);

  import cgra_pkg::*;

  seq_t seq_cnt [num_threads];

  assign pop = drain_en && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      for (int t = 0; t < num_threads; t++) begin
        seq_cnt[t] <= '0;
      end
    end else begin
      out_valid <= pop;
      if (pop) begin
        seq_cnt[pop_data.thread] <= seq_cnt[pop_data.thread] + 1'b1;
      end
    end
  end

  // Sequence number is the count before this word.
  always_ff @(posedge clk) begin
    if (pop) begin
      out_word <= '{
        thread: pop_data.thread,
        seq:    seq_cnt[pop_data.thread],
        data:   pop_data.data
      };
    end
  end

endmodule

/* rtl/cgra_out_top.sv */
`timescale 1ns/1ps

module cgra_out_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 conf_valid,
  input  cgra_pkg::conf_word_t conf_word,
  input  logic                 run,
  input  cgra_pkg::data_t      ina,
  input  cgra_pkg::data_t      inb,
  input  logic                 drain_en,
  output cgra_pkg::data_t      outa,
  output logic                 out_valid,
  output cgra_pkg::out_word_t  out_word,
  output logic                 done
);

  import cgra_pkg::*;

  logic       conf_we;
  conf_kind_e conf_kind;
  thread_t    conf_thread;
  pc_t        conf_addr;
  data_t      conf_data;
  logic       push;
  result_t    push_data;
  logic       pop;
  result_t    pop_data;
  logic       empty;
  logic       space;

  cgra_conf_reader #(
    .PE_ID(4'd0)
  ) conf_reader (
    .clk(clk),
    .rst(rst),
    .conf_valid(conf_valid),
    .conf_word(conf_word),
    .conf_we(conf_we),
    .conf_kind(conf_kind),
    .conf_thread(conf_thread),
    .conf_addr(conf_addr),
    .conf_data(conf_data)
  );

  cgra_pe_out pe (
    .clk(clk),
    .rst(rst),
    .run(run),
    .space(space),
    .conf_we(conf_we),
    .conf_kind(conf_kind),
    .conf_thread(conf_thread),
    .conf_addr(conf_addr),
    .conf_data(conf_data),
    .ina(ina),
    .inb(inb),
    .push(push),
    .push_data(push_data),
    .outa(outa),
    .done(done)
  );

  cgra_out_fifo fifo (
    .clk(clk),
    .rst(rst),
    .push(push),
    .push_data(push_data),
    .pop(pop),
    .pop_data(pop_data),
    .empty(empty),
    .space(space)
  );

  cgra_out_drain drain (
    .clk(clk),
    .rst(rst),
    .drain_en(drain_en),
    .empty(empty),
    .pop_data(pop_data),
    .pop(pop),
    .out_valid(out_valid),
    .out_word(out_word)
  );

endmodule

/* dv/tb_cgra_out.sv */
`timescale 1ns/1ps

module tb_cgra_out;

  import cgra_pkg::*;

  localparam int num_rows = 6;
  localparam int run_timeout = 5000;
  localparam int drain_timeout = 200;
  localparam logic [15:0] lfsr_seed = 16'd64048;

  typedef struct packed {
    logic [7:0][3:0]  op;        // One nibble per thread, low three bits used.
    logic [7:0]       bconst;
    logic [7:0][15:0] cval;
    logic [7:0][3:0]  ign;
    logic [7:0][3:0]  qty;
    logic             two_inst;
    logic [2:0]       op1;       // Second instruction always works on inb.
    logic             emit1;
    logic             ina_free;
    data_t            ina_hold;
    data_t            inb;
    logic             drain_rand;
  } row_t;

  logic       clk;
  logic       rst;
  logic       conf_valid;
  conf_word_t conf_word;
  logic       run;
  data_t      ina;
  data_t      inb;
  logic       drain_en;
  data_t      outa;
  logic       out_valid;
  out_word_t  out_word;
  logic       done;

  row_t        rows [num_rows];
  row_t        cur;
  int          cur_row;
  int          cyc;
  logic [15:0] lfsr_state;
  data_t       exp_q [num_threads][$];
  data_t       exp_outa;
  int          got_cnt [num_threads];
  int          mismatches;
  int          timeouts;

  cgra_out_top uut (
    .clk(clk),
    .rst(rst),
    .conf_valid(conf_valid),
    .conf_word(conf_word),
    .run(run),
    .ina(ina),
    .inb(inb),
    .drain_en(drain_en),
    .outa(outa),
    .out_valid(out_valid),
    .out_word(out_word),
    .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // **************************************************
  // Stimulus table.
  // **************************************************
  task automatic fill_table();
    rows[0] = '{op: 32'h76543210, bconst: 8'h00, cval: '0, ign: 32'h00000000,
                qty: 32'h33333333, two_inst: 1'b0, op1: 3'd0, emit1: 1'b0, ina_free: 1'b1,
                ina_hold: 16'h0000, inb: 16'h0013, drain_rand: 1'b0};
    rows[1] = '{op: 32'h01234567, bconst: 8'hFF,
                cval: 128'h8001_0005_00F0_0FFF_0011_7FFF_0003_FFFE, ign: 32'h01203012,
                qty: 32'h45230452, two_inst: 1'b0, op1: 3'd0, emit1: 1'b0, ina_free: 1'b1,
                ina_hold: 16'h0000, inb: 16'hAAAA, drain_rand: 1'b0};
    rows[2] = '{op: 32'h32107654, bconst: 8'hA5,
                cval: 128'h0007_1000_0002_00FF_F00F_0010_0003_0020, ign: 32'h10203010,
                qty: 32'h66666666, two_inst: 1'b1, op1: 3'd2, emit1: 1'b1, ina_free: 1'b1,
                ina_hold: 16'h0000, inb: 16'h0009, drain_rand: 1'b0};
    rows[3] = '{op: 32'h54321076, bconst: 8'h3C,
                cval: 128'h1111_2222_0004_0008_00AA_5555_0006_0001, ign: 32'h21000012,
                qty: 32'h55550555, two_inst: 1'b1, op1: 3'd6, emit1: 1'b0, ina_free: 1'b1,
                ina_hold: 16'h0000, inb: 16'h0101, drain_rand: 1'b0};
    rows[4] = '{op: 32'h76543210, bconst: 8'h0F,
                cval: 128'h0F0F_1234_0002_C000_0100_00FF_4321_0001, ign: 32'h00000000,
                qty: 32'hFFFFFFFF, two_inst: 1'b1, op1: 3'd6, emit1: 1'b1, ina_free: 1'b0,
                ina_hold: 16'hBEEF, inb: 16'h1357, drain_rand: 1'b1};
    rows[5] = '{op: 32'h12345670, bconst: 8'hF0,
                cval: 128'h0003_8000_00FF_0F00_0005_0006_0007_0008, ign: 32'h12345670,
                qty: 32'hCCCCC0CC, two_inst: 1'b0, op1: 3'd0, emit1: 1'b0, ina_free: 1'b0,
                ina_hold: 16'h0042, inb: 16'h00FF, drain_rand: 1'b1};
  endtask

  // **************************************************
  // Reference model.
  // **************************************************
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16, 14, 13, 11.
  endfunction

  function automatic data_t ref_alu(input logic [2:0] op, input data_t a, input data_t b);
    logic [31:0] prod;
    prod = 32'(a) * 32'(b);
    case (op)
      3'd0: return a;
      3'd1: return a + b;
      3'd2: return a - b;
      3'd3: return prod[15:0];
      3'd4: return a & b;
      3'd5: return a | b;
      3'd6: return a ^ b;
      default: return (b > a) ? b : a;
    endcase
  endfunction

  // Walks each thread's issues in order and keeps the emitted results.
  task automatic build_expected();
    int k;
    int skipped;
    data_t a;
    data_t b;
    logic [2:0] op;
    logic em;
    for (int t = 0; t < num_threads; t++) begin
      exp_q[t].delete();
      skipped = 0;
      k = 0;
      while (exp_q[t].size() < int'(cur.qty[t]) && k < 1000) begin
        a = cur.ina_free ? data_t'(8 * k + t + 1) : cur.ina_hold;
        if (cur.two_inst && (k % 2 == 1)) begin
          op = cur.op1;
          b = cur.inb;
          em = cur.emit1;
        end else begin
          op = cur.op[t][2:0];
          b = cur.bconst[t] ? cur.cval[t] : cur.inb;
          em = 1'b1;
        end
        if (em && skipped < int'(cur.ign[t])) begin
          skipped++;
        end else if (em) begin
          exp_q[t].push_back(ref_alu(op, a, b));
        end
        k++;
      end
    end
  endtask

  // **************************************************
  // Drivers and monitors.
  // **************************************************
  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    run = 1'b0;
    drain_en = 1'b0;
    conf_valid = 1'b0;
    repeat (10) @(negedge clk);
    assert (!out_valid && !done && outa == '0) else begin
      mismatches++;
      $display("mismatch at %0t: outputs not idle in reset, row %0d", $time, cur_row);
    end
    rst = 1'b0;
  endtask

  // Each real word is followed by a decoy for another PE.
  task automatic send_conf(input conf_kind_e k, input thread_t th, input pc_t a, input data_t d);
    @(negedge clk);
    conf_valid = 1'b1;
    conf_word = '{pe_id: 4'h0, kind: k, thread: th, addr: a, reserved: 1'b0, data: d};
    @(negedge clk);
    conf_word = '{pe_id: 4'h6, kind: k, thread: th, addr: a, reserved: 1'b0, data: ~d};
  endtask

  task automatic configure();
    inst_t i0;
    inst_t i1;
    const_addr_t ca;
    for (int t = 0; t < num_threads; t++) begin
      ca = const_addr_t'(t ^ 9);
      i0 = '{op: alu_op_e'(cur.op[t][2:0]), b_const: cur.bconst[t], const_addr: ca,
             emit: 1'b1, out_en: 1'b1, spare: '0};
      i1 = '{op: alu_op_e'(cur.op1), b_const: 1'b0, const_addr: '0,
             emit: cur.emit1, out_en: 1'b0, spare: '0};
      send_conf(kind_inst, thread_t'(t), pc_t'(0), data_t'(i0));
      if (cur.two_inst) begin
        send_conf(kind_inst, thread_t'(t), pc_t'(1), data_t'(i1));
      end
      send_conf(kind_const, thread_t'(t), pc_t'(ca), cur.cval[t]);
      send_conf(kind_pc_max, thread_t'(t), '0, cur.two_inst ? 16'd1 : 16'd0);
      send_conf(kind_pc_loop, thread_t'(t), '0, 16'd0);
      send_conf(kind_ignore, thread_t'(t), '0, data_t'(cur.ign[t]));
      send_conf(kind_qty, thread_t'(t), '0, data_t'(cur.qty[t]));
    end
    @(negedge clk);
    conf_valid = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic check_word(input out_word_t w);
    int t;
    int idx;
    t = int'(w.thread);
    idx = got_cnt[t];
    assert (idx < exp_q[t].size()) else begin
      mismatches++;
      $display("mismatch at %0t: extra word %h from thread %0d, row %0d",
               $time, w.data, t, cur_row);
    end
    if (idx < exp_q[t].size()) begin
      assert (w.data == exp_q[t][idx]) else begin
        mismatches++;
        $display("mismatch at %0t: thread %0d word %0d is %h, expected %h, row %0d",
                 $time, t, idx, w.data, exp_q[t][idx], cur_row);
      end
      assert (w.seq == seq_t'(idx)) else begin
        mismatches++;
        $display("mismatch at %0t: thread %0d seq %0d, expected %0d, row %0d",
                 $time, t, w.seq, idx, cur_row);
      end
    end
    got_cnt[t] = idx + 1;
  endtask

  // Every cycle is a step here, so issue cyc-4 has just left the ALU stage.
  task automatic check_outa();
    int i;
    int t;
    int k;
    data_t a;
    data_t b;
    if (cyc >= 4) begin
      i = cyc - 4;
      t = i % num_threads;
      k = i / num_threads;
      if (!(cur.two_inst && (k % 2 == 1))) begin
        a = cur.ina_free ? data_t'(8 * k + t + 1) : cur.ina_hold;
        b = cur.bconst[t] ? cur.cval[t] : cur.inb;
        exp_outa = ref_alu(cur.op[t][2:0], a, b);
      end
    end
    assert (outa == exp_outa) else begin
      mismatches++;
      $display("mismatch at %0t: outa is %h, expected %h, row %0d",
               $time, outa, exp_outa, cur_row);
    end
  endtask

  task automatic clock_cycle(input logic force_drain);
    @(negedge clk);
    cyc++;
    if (cur.ina_free) begin
      ina = data_t'(cyc);  // Cycles since run rose.
    end
    if (force_drain || !cur.drain_rand) begin
      drain_en = 1'b1;
    end else begin
      lfsr_state = lfsr_step(lfsr_state);
      drain_en = lfsr_state[0];
    end
    if (!cur.drain_rand) begin
      check_outa();
    end
    if (out_valid) begin
      check_word(out_word);
    end
  endtask

  task automatic run_row();
    int waited;
    int quiet;
    for (int t = 0; t < num_threads; t++) begin
      got_cnt[t] = 0;
    end
    @(negedge clk);
    cyc = 0;
    exp_outa = '0;
    ina = cur.ina_free ? '0 : cur.ina_hold;
    inb = cur.inb;
    run = 1'b1;
    waited = 0;
    while (!done && waited < run_timeout) begin
      clock_cycle(1'b0);
      waited++;
    end
    if (!done) begin
      timeouts++;
      $display("row %0d: done never rose", cur_row);
    end
    quiet = 0;
    waited = 0;
    while (quiet < 3 && waited < drain_timeout) begin
      clock_cycle(1'b1);
      quiet = out_valid ? 0 : quiet + 1;
      waited++;
    end
    if (quiet < 3) begin
      timeouts++;
      $display("row %0d: output words kept coming after done", cur_row);
    end
    run = 1'b0;
    drain_en = 1'b0;
    for (int t = 0; t < num_threads; t++) begin
      assert (got_cnt[t] == exp_q[t].size()) else begin
        mismatches++;
        $display("mismatch at %0t: thread %0d gave %0d words, expected %0d, row %0d",
                 $time, t, got_cnt[t], exp_q[t].size(), cur_row);
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    run = 1'b0;
    conf_valid = 1'b0;
    conf_word = '0;
    ina = '0;
    inb = '0;
    drain_en = 1'b0;
    mismatches = 0;
    timeouts = 0;
    cyc = 0;
    exp_outa = '0;
    cur = '0;
    cur_row = 0;
    lfsr_state = lfsr_seed;
    fill_table();
    for (int i = 0; i < num_rows; i++) begin
      cur_row = i;
      cur = rows[i];
      apply_reset();
      configure();
      build_expected();
      run_row();
    end
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* all.f */
rtl/cgra_pkg.sv
rtl/cgra_conf_reader.sv
rtl/cgra_pe_out.sv
rtl/cgra_out_fifo.sv
rtl/cgra_out_drain.sv
rtl/cgra_out_top.sv
dv/tb_cgra_out.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cgra_out
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
